// ==== build.f ====
hdl/execPkg.sv
hdl/aluUnit.sv
hdl/mulUnit.sv
hdl/cdbArbiter.sv
hdl/execCluster.sv
dv/execCluster_properties.sv
dv/execCluster_tb.sv

// ==== Makefile ====
TOP := execCluster_tb

.PHONY: all lint clean

all:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "sim failed" sim.log; then exit 1; fi
	@grep -q "sim passed" sim.log

lint:
	verilator --lint-only -Wall --top-module execCluster hdl/execPkg.sv hdl/aluUnit.sv \
		hdl/mulUnit.sv hdl/cdbArbiter.sv hdl/execCluster.sv

clean:
	rm -rf obj_dir sim.log

// ==== dv/execCluster_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCluster_tb import execPkg::*; ();

    localparam int tagWidth = 4;

    typedef struct packed {
        logic isMul;
        aluOp_t op;
        logic [xlen-1:0] pc;
        logic [xlen-1:0] imm;
        logic [xlen-1:0] src1;
        logic [xlen-1:0] src2;
        logic [tagWidth-1:0] tag;
        logic [xlen-1:0] expData;
        logic expTaken;
        logic [xlen-1:0] expTarget;
    } stim_t;

    logic clk = 1'b0;
    logic rst;
    logic aluIssue;
    aluOp_t aluOp;
    logic [xlen-1:0] aluPc;
    logic [xlen-1:0] aluImm;
    logic [tagWidth-1:0] aluTag;
    logic [xlen-1:0] aluSrc1;
    logic [xlen-1:0] aluSrc2;
    logic mulIssue;
    logic [tagWidth-1:0] mulTag;
    logic [xlen-1:0] mulSrc1;
    logic [xlen-1:0] mulSrc2;
    logic aluReady;
    logic mulReady;
    logic cdbValid;
    logic [tagWidth-1:0] cdbTag;
    logic [xlen-1:0] cdbData;
    logic cdbTaken;
    logic [xlen-1:0] cdbTarget;

    stim_t stimTable[$];
    logic [31:0] lcgState;
    int aluCount = 0;
    int mulCount = 0;
    int received = 0;
    int mismatchCount = 0;
    int failCount = 0;
    int watchCycles = 0;
    logic aluPending = 1'b0;
    logic mulPending = 1'b0;

    // Expected results of the operations in flight, indexed by tag.
    logic pendValid [2**tagWidth];
    logic pendIsMul [2**tagWidth];
    logic [xlen-1:0] pendData [2**tagWidth];
    logic pendTaken [2**tagWidth];
    logic [xlen-1:0] pendTarget [2**tagWidth];

    execCluster u_execCluster (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1103515245 + 32'd12345;
        return lcgState;
    endfunction

    function automatic logic signedLess(input logic [31:0] a, input logic [31:0] b);
        return (a[31] != b[31]) ? a[31] : (a < b); // Differing signs decide on their own.
    endfunction

    function automatic void expectAlu(input aluOp_t op, input logic [31:0] pc,
            input logic [31:0] imm, input logic [31:0] a, input logic [31:0] b,
            output logic [31:0] d, output logic t, output logic [31:0] tgt);
        logic [31:0] opB;
        logic [4:0] sh;
        logic [63:0] ext;
        logic cond;
        d = 32'd0;
        t = 1'b0;
        tgt = 32'd0;
        cond = 1'b0;
        opB = (op inside {ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND}) ? b : imm;
        sh = opB[4:0];
        ext = {{32{a[31]}}, a} >> sh; // Sign bits fill in from the upper word.
        case (op)
            LUI:         d = imm;
            AUIPC:       d = pc + imm;
            ADDI, ADD:   d = a + opB;
            SUB:         d = a - b;
            SLTI, SLT:   d = {31'd0, signedLess(a, opB)};
            SLTIU, SLTU: d = {31'd0, a < opB};
            XORI, XOR:   d = a ^ opB;
            ORI, OR:     d = a | opB;
            ANDI, AND:   d = a & opB;
            SLLI, SLL:   d = a << sh;
            SRLI, SRL:   d = a >> sh;
            SRAI, SRA:   d = ext[31:0];
            JAL, JALR: begin
                d = pc + linkOffset;
                t = 1'b1;
                tgt = (op == JAL) ? pc + imm : (a + imm) & 32'hFFFF_FFFE;
            end
            default: begin
                case (op)
                    BEQ:     cond = (a == b);
                    BNE:     cond = (a != b);
                    BLT:     cond = signedLess(a, b);
                    BGE:     cond = !signedLess(a, b);
                    BLTU:    cond = (a < b);
                    default: cond = !(a < b);
                endcase
                t = cond;
                tgt = cond ? pc + imm : 32'd0;
            end
        endcase
    endfunction

    task automatic addMul(input logic [31:0] s1, input logic [31:0] s2);
        stim_t e;
        e = '0;
        e.isMul = 1'b1;
        e.src1 = s1;
        e.src2 = s2;
        e.tag = tagWidth'(8 + mulCount % 8); // Upper half of the tag space.
        e.expData = s1 * s2;
        stimTable.push_back(e);
        mulCount++;
    endtask

    task automatic addAlu(input aluOp_t op, input logic [31:0] pc, input logic [31:0] imm,
            input logic [31:0] s1, input logic [31:0] s2);
        stim_t e;
        e = '0;
        e.op = op;
        e.pc = pc;
        e.imm = imm;
        e.src1 = s1;
        e.src2 = s2;
        e.tag = tagWidth'(aluCount % 8);
        expectAlu(op, pc, imm, s1, s2, e.expData, e.expTaken, e.expTarget);
        stimTable.push_back(e);
        aluCount++;
        // A multiply every few entries keeps both units busy at once.
        if (aluCount % 6 == 0) addMul(nextRand(), nextRand());
    endtask

    task automatic checkField(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        assert (expected == actual) else begin
            $display("Mismatch at %0t ns: %s expected %h, got %h", $time, name, expected, actual);
            mismatchCount++;
        end
    endtask

    task automatic applyEntry(input stim_t e);
        while ((e.isMul ? mulReady : aluReady) !== 1'b1) begin
            @(posedge clk);
            #1;
        end
        if (e.isMul) begin
            assert (!mulPending) else begin
                $display("Multiplier took a new issue before its last result reached the CDB");
                failCount++;
            end
            mulPending = 1'b1;
            mulTag = e.tag;
            mulSrc1 = e.src1;
            mulSrc2 = e.src2;
            mulIssue = 1'b1;
        end else begin
            assert (!aluPending) else begin
                $display("Integer unit took a new issue before its last result reached the CDB");
                failCount++;
            end
            aluPending = 1'b1;
            aluOp = e.op;
            aluPc = e.pc;
            aluImm = e.imm;
            aluTag = e.tag;
            aluSrc1 = e.src1;
            aluSrc2 = e.src2;
            aluIssue = 1'b1;
        end
        pendValid[e.tag] = 1'b1;
        pendIsMul[e.tag] = e.isMul;
        pendData[e.tag] = e.expData;
        pendTaken[e.tag] = e.expTaken;
        pendTarget[e.tag] = e.expTarget;
        @(posedge clk);
        #1;
        aluIssue = 1'b0;
        mulIssue = 1'b0;
    endtask

    // CDB outputs are registered, so the falling edge sees them settled.
    always @(negedge clk) begin
        if (!rst && cdbValid) begin
            assert (pendValid[cdbTag]) else begin
                $display("Result with tag %0d appeared on the CDB at %0t ns but none was in flight",
                    cdbTag, $time);
                failCount++;
            end
            if (pendValid[cdbTag]) begin
                checkField("cdbData", pendData[cdbTag], cdbData);
                checkField("cdbTaken", 32'(pendTaken[cdbTag]), 32'(cdbTaken));
                checkField("cdbTarget", pendTarget[cdbTag], cdbTarget);
                pendValid[cdbTag] = 1'b0;
                if (pendIsMul[cdbTag]) mulPending = 1'b0;
                else aluPending = 1'b0;
                received++;
            end
        end
    end

    initial begin
        wait (watchCycles > 0);
        repeat (watchCycles) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", watchCycles);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst = 1'b1;
        aluIssue = 1'b0;
        aluOp = LUI;
        aluPc = '0;
        aluImm = '0;
        aluTag = '0;
        aluSrc1 = '0;
        aluSrc2 = '0;
        mulIssue = 1'b0;
        mulTag = '0;
        mulSrc1 = '0;
        mulSrc2 = '0;
        lcgState = 32'h88e2;
        foreach (pendValid[i]) pendValid[i] = 1'b0;

        // Fixed operands first, then random ones, for every data operation.
        for (int k = 0; k < 29; k++) begin
            if (k >= int'(BEQ) && k <= int'(JALR)) continue;
            addAlu(aluOp_t'(k), 32'h0000_1000, 32'h0000_0007, 32'hFFFF_FFF0, 32'h0000_0005);
            addAlu(aluOp_t'(k), nextRand(), nextRand(), nextRand(), nextRand());
        end
        // Issued just after the previous multiply, so its request meets the sixth
        // integer request that follows and has to wait for the CDB.
        addMul(32'hFFFF_FFFD, 32'd7);
        addAlu(SRA, 32'd0, 32'd0, 32'h8000_0000, 32'h0000_003F);
        addAlu(SRL, 32'd0, 32'd0, 32'h8000_0000, 32'h0000_0020); // Amount wraps to zero.
        addAlu(SUB, 32'd0, 32'd0, 32'd0, 32'd1);
        for (int k = int'(BEQ); k <= int'(BGEU); k++) begin
            addAlu(aluOp_t'(k), 32'h0000_0100, 32'hFFFF_FFF0, 32'hFFFF_FFFD, 32'hFFFF_FFFD);
            addAlu(aluOp_t'(k), 32'h0000_0100, 32'hFFFF_FFF0, 32'hFFFF_FFFD, 32'h0000_0005);
            addAlu(aluOp_t'(k), 32'h0000_0100, 32'hFFFF_FFF0, 32'h0000_0005, 32'hFFFF_FFFD);
        end
        addAlu(JAL, 32'h0000_0200, 32'h0000_0040, 32'd0, 32'd0);
        addAlu(JALR, 32'h0000_0200, 32'h0000_0012, 32'h0000_1001, 32'd0);
        addMul(32'hFFFF_FFFF, 32'hFFFF_FFFF);
        addAlu(ADD, 32'd0, 32'd0, 32'h7FFF_FFFF, 32'd1);
        watchCycles = stimTable.size() * 40 + 100;

        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        checkField("cdbValid", 32'd0, 32'(cdbValid));
        checkField("aluReady", 32'd1, 32'(aluReady));
        checkField("mulReady", 32'd1, 32'(mulReady));

        foreach (stimTable[i]) applyEntry(stimTable[i]);
        wait (!aluPending && !mulPending);
        repeat (5) @(posedge clk);
        assert (received == stimTable.size()) else begin
            $display("Only %0d of %0d results appeared on the CDB", received, stimTable.size());
            failCount++;
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatchCount, failCount);
        if (mismatchCount == 0 && failCount == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== dv/execCluster_properties.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCluster_properties (
    input wire logic clk,
    input wire logic rst,
    input wire logic aluReq,
    input wire logic mulReq,
    input wire logic aluAck,
    input wire logic mulAck,
    input wire logic cdbValid
);

    // A request stays up until the arbiter answers it.
    aluReqHeld: assert property (@(posedge clk) disable iff (rst) (aluReq && !aluAck) |=> aluReq)
        else $error("Integer unit dropped its request before the acknowledge");
    mulReqHeld: assert property (@(posedge clk) disable iff (rst) (mulReq && !mulAck) |=> mulReq)
        else $error("Multiplier dropped its request before the acknowledge");

    aluAckHasReq: assert property (@(posedge clk) disable iff (rst) $rose(aluAck) |-> aluReq)
        else $error("Integer unit acknowledge rose without a request");
    mulAckHasReq: assert property (@(posedge clk) disable iff (rst) $rose(mulAck) |-> mulReq)
        else $error("Multiplier acknowledge rose without a request");

    ackExclusive: assert property (@(posedge clk) disable iff (rst) !(aluAck && mulAck))
        else $error("Both acknowledges are high together");

    ackGivesValid: assert property (@(posedge clk) disable iff (rst)
            ($rose(aluAck) || $rose(mulAck)) |-> cdbValid)
        else $error("Acknowledge rose without a CDB valid cycle");
    validNeedsAck: assert property (@(posedge clk) disable iff (rst)
            cdbValid |-> ($rose(aluAck) || $rose(mulAck)))
        else $error("CDB valid without a newly raised acknowledge");
    validSingle: assert property (@(posedge clk) disable iff (rst) cdbValid |=> !cdbValid)
        else $error("CDB valid lasted more than one cycle");

endmodule

bind cdbArbiter execCluster_properties u_properties (
    .clk(clk),
    .rst(rst),
    .aluReq(aluReq),
    .mulReq(mulReq),
    .aluAck(aluAck),
    .mulAck(mulAck),
    .cdbValid(cdbValid)
);

`default_nettype wire

// ==== hdl/execCluster.sv ====
`timescale 1ns/1ns
`default_nettype none

module execCluster import execPkg::*; #(
    parameter int tagWidth = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                aluIssue,
    input  wire aluOp_t              aluOp,
    input  wire logic [xlen-1:0]     aluPc,
    input  wire logic [xlen-1:0]     aluImm,
    input  wire logic [tagWidth-1:0] aluTag,
    input  wire logic [xlen-1:0]     aluSrc1,
    input  wire logic [xlen-1:0]     aluSrc2,
    input  wire logic                mulIssue,
    input  wire logic [tagWidth-1:0] mulTag,
    input  wire logic [xlen-1:0]     mulSrc1,
    input  wire logic [xlen-1:0]     mulSrc2,
    output logic                     aluReady,
    output logic                     mulReady,
    output logic                     cdbValid,
    output logic [tagWidth-1:0]      cdbTag,
    output logic [xlen-1:0]          cdbData,
    output logic                     cdbTaken,
    output logic [xlen-1:0]          cdbTarget
);

    logic aluReq;
    logic aluAck;
    logic [tagWidth-1:0] aluResTag;
    logic [xlen-1:0] aluResData;
    logic aluResTaken;
    logic [xlen-1:0] aluResTarget;
    logic mulReq;
    logic mulAck;
    logic [tagWidth-1:0] mulResTag;
    logic [xlen-1:0] mulResData;

    aluUnit #(.tagWidth(tagWidth)) u_aluUnit (
        .clk(clk), .rst(rst),
        .aluIssue(aluIssue), .aluOp(aluOp), .aluPc(aluPc), .aluImm(aluImm),
        .aluTag(aluTag), .aluSrc1(aluSrc1), .aluSrc2(aluSrc2), .aluAck(aluAck),
        .aluReady(aluReady), .aluReq(aluReq), .aluResTag(aluResTag),
        .aluResData(aluResData), .aluResTaken(aluResTaken), .aluResTarget(aluResTarget)
    );

    mulUnit #(.tagWidth(tagWidth)) u_mulUnit (
        .clk(clk), .rst(rst),
        .mulIssue(mulIssue), .mulTag(mulTag), .mulSrc1(mulSrc1), .mulSrc2(mulSrc2),
        .mulAck(mulAck), .mulReady(mulReady), .mulReq(mulReq),
        .mulResTag(mulResTag), .mulResData(mulResData)
    );

    // Both result paths meet here and leave as one registered CDB.
    cdbArbiter #(.tagWidth(tagWidth)) u_cdbArbiter (
        .clk(clk), .rst(rst),
        .aluReq(aluReq), .aluResTag(aluResTag), .aluResData(aluResData),
        .aluResTaken(aluResTaken), .aluResTarget(aluResTarget),
        .mulReq(mulReq), .mulResTag(mulResTag), .mulResData(mulResData),
        .aluAck(aluAck), .mulAck(mulAck),
        .cdbValid(cdbValid), .cdbTag(cdbTag), .cdbData(cdbData),
        .cdbTaken(cdbTaken), .cdbTarget(cdbTarget)
    );

endmodule

`default_nettype wire

// ==== hdl/cdbArbiter.sv ====
`timescale 1ns/1ns
`default_nettype none

module cdbArbiter import execPkg::*; #(
    parameter int tagWidth = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                aluReq,
    input  wire logic [tagWidth-1:0] aluResTag,
    input  wire logic [xlen-1:0]     aluResData,
    input  wire logic                aluResTaken,
    input  wire logic [xlen-1:0]     aluResTarget,
    input  wire logic                mulReq,
    input  wire logic [tagWidth-1:0] mulResTag,
    input  wire logic [xlen-1:0]     mulResData,
    output logic                     aluAck,
    output logic                     mulAck,
    output logic                     cdbValid,
    output logic [tagWidth-1:0]      cdbTag,
    output logic [xlen-1:0]          cdbData,
    output logic                     cdbTaken,
    output logic [xlen-1:0]          cdbTarget
);

    logic lastMul; // Set when the multiplier was served last.
    logic free;
    logic grantAlu;
    logic grantMul;

    // No new grant while either handshake is still open, so the acks never overlap.
    assign free = !aluAck && !mulAck;
    assign grantAlu = free && aluReq && (!mulReq || lastMul);
    assign grantMul = free && mulReq && !grantAlu;

    always_ff @(posedge clk) begin
        if (rst) begin
            aluAck <= 1'b0;
            mulAck <= 1'b0;
            cdbValid <= 1'b0;
            lastMul <= 1'b0;
        end else begin
            cdbValid <= grantAlu || grantMul;
            if (grantAlu) begin
                aluAck <= 1'b1;
                lastMul <= 1'b0;
            end else if (!aluReq) begin
                aluAck <= 1'b0;
            end
            if (grantMul) begin
                mulAck <= 1'b1;
                lastMul <= 1'b1;
            end else if (!mulReq) begin
                mulAck <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grantAlu) begin
            cdbTag <= aluResTag;
            cdbData <= aluResData;
            cdbTaken <= aluResTaken;
            cdbTarget <= aluResTarget;
        end else if (grantMul) begin
            cdbTag <= mulResTag;
            cdbData <= mulResData;
            cdbTaken <= noJump;
            cdbTarget <= '0;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/mulUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module mulUnit import execPkg::*; #(
    parameter int tagWidth = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                mulIssue,
    input  wire logic [tagWidth-1:0] mulTag,
    input  wire logic [xlen-1:0]     mulSrc1,
    input  wire logic [xlen-1:0]     mulSrc2,
    input  wire logic                mulAck,
    output logic                     mulReady,
    output logic                     mulReq,
    output logic [tagWidth-1:0]      mulResTag,
    output logic [xlen-1:0]          mulResData
);

    typedef enum logic [2:0] {IDLE, RUN, FIN, REQ, WAITACK} state_t;

    state_t state;
    logic [4:0] step;
    logic [xlen-1:0] multiplicand;
    logic [xlen-1:0] multiplier;
    logic [xlen-1:0] acc;

    assign mulReady = (state == IDLE);
    assign mulReq = (state == REQ);

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
            step <= '0;
        end else begin
            case (state)
                IDLE: begin
                    step <= '0;
                    if (mulIssue) state <= RUN;
                end
                RUN: begin
                    step <= step + 5'd1;
                    if (step == 5'd31) state <= FIN; // Last of the 32 steps.
                end
                FIN:     state <= REQ;
                REQ:     if (mulAck) state <= WAITACK;
                WAITACK: if (!mulAck) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && mulIssue) begin
            multiplicand <= mulSrc1;
            multiplier <= mulSrc2;
            acc <= '0;
            mulResTag <= mulTag;
        end
        if (state == RUN) begin
            // Bits shifted past the top are dropped, leaving the low word of the product.
            if (multiplier[0]) acc <= acc + multiplicand;
            multiplicand <= multiplicand << 1;
            multiplier <= multiplier >> 1;
        end
        if (state == FIN) begin
            mulResData <= acc;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/aluUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module aluUnit import execPkg::*; #(
    parameter int tagWidth = 4
) (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                aluIssue,
    input  wire aluOp_t              aluOp,
    input  wire logic [xlen-1:0]     aluPc,
    input  wire logic [xlen-1:0]     aluImm,
    input  wire logic [tagWidth-1:0] aluTag,
    input  wire logic [xlen-1:0]     aluSrc1,
    input  wire logic [xlen-1:0]     aluSrc2,
    input  wire logic                aluAck,
    output logic                     aluReady,
    output logic                     aluReq,
    output logic [tagWidth-1:0]      aluResTag,
    output logic [xlen-1:0]          aluResData,
    output logic                     aluResTaken,
    output logic [xlen-1:0]          aluResTarget
);

    typedef enum logic [1:0] {IDLE, EXEC, REQ, WAITACK} state_t;

    state_t state;
    aluOp_t opReg;
    logic [xlen-1:0] pcReg;
    logic [xlen-1:0] immReg;
    logic [xlen-1:0] src1Reg;
    logic [xlen-1:0] src2Reg;
    logic [xlen-1:0] data;
    logic taken;
    logic [xlen-1:0] target;
    logic [xlen-1:0] branchTarget;

    assign aluReady = (state == IDLE);
    assign aluReq = (state == REQ);
    assign branchTarget = pcReg + immReg;

    always_comb begin
        data = '0;
        taken = noJump;
        target = '0;
        case (opReg)
            LUI:   data = immReg;
            AUIPC: data = pcReg + immReg;
            BEQ:   taken = (src1Reg == src2Reg);
            BNE:   taken = (src1Reg != src2Reg);
            BLT:   taken = ($signed(src1Reg) < $signed(src2Reg));
            BGE:   taken = ($signed(src1Reg) >= $signed(src2Reg));
            BLTU:  taken = (src1Reg < src2Reg);
            BGEU:  taken = (src1Reg >= src2Reg);
            JAL: begin
                data = pcReg + linkOffset;
                taken = jump;
                target = branchTarget;
            end
            JALR: begin
                data = pcReg + linkOffset;
                taken = jump;
                target = (src1Reg + immReg) & ~32'd1; // Bit 0 is always cleared.
            end
            ADDI:  data = src1Reg + immReg;
            SLTI:  data = {31'd0, $signed(src1Reg) < $signed(immReg)};
            SLTIU: data = {31'd0, src1Reg < immReg};
            XORI:  data = src1Reg ^ immReg;
            ORI:   data = src1Reg | immReg;
            ANDI:  data = src1Reg & immReg;
            SLLI:  data = src1Reg << immReg[4:0];
            SRLI:  data = src1Reg >> immReg[4:0];
            SRAI:  data = $signed(src1Reg) >>> immReg[4:0];
            ADD:   data = src1Reg + src2Reg;
            SUB:   data = src1Reg - src2Reg;
            SLL:   data = src1Reg << src2Reg[4:0];
            SLT:   data = {31'd0, $signed(src1Reg) < $signed(src2Reg)};
            SLTU:  data = {31'd0, src1Reg < src2Reg};
            XOR:   data = src1Reg ^ src2Reg;
            SRL:   data = src1Reg >> src2Reg[4:0];
            SRA:   data = $signed(src1Reg) >>> src2Reg[4:0];
            OR:    data = src1Reg | src2Reg;
            AND:   data = src1Reg & src2Reg;
            default: data = '0;
        endcase
        // Conditional branches only carry a target when they are taken.
        if (opReg inside {BEQ, BNE, BLT, BGE, BLTU, BGEU} && taken) begin
            target = branchTarget;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (aluIssue) state <= EXEC;
                EXEC:    state <= REQ;
                REQ:     if (aluAck) state <= WAITACK;
                WAITACK: if (!aluAck) state <= IDLE; // Free once the arbiter lets go.
                default: state <= IDLE;
            endcase
        end
    end

    // Operands are captured on issue and the result one cycle later.
    always_ff @(posedge clk) begin
        if (state == IDLE && aluIssue) begin
            opReg <= aluOp;
            pcReg <= aluPc;
            immReg <= aluImm;
            src1Reg <= aluSrc1;
            src2Reg <= aluSrc2;
            aluResTag <= aluTag;
        end
        if (state == EXEC) begin
            aluResData <= data;
            aluResTaken <= taken;
            aluResTarget <= target;
        end
    end

endmodule

`default_nettype wire

// ==== hdl/execPkg.sv ====
`default_nettype none

package execPkg;

    localparam int xlen = 32;

    // Link value added to pc by JAL and JALR.
    localparam logic [xlen-1:0] linkOffset = 32'd4;

    // Branch outcome as it goes out on the CDB.
    localparam logic jump = 1'b1;
    localparam logic noJump = 1'b0;

    typedef enum logic [4:0] {
        LUI,
        AUIPC,
        BEQ,
        BNE,
        BLT,
        BGE,
        BLTU,
        BGEU,
        JAL,
        JALR,
        ADDI,
        SLTI,
        SLTIU,
        XORI,
        ORI,
        ANDI,
        SLLI,
        SRLI,
        SRAI,
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND
    } aluOp_t;

endpackage

`default_nettype wire
